/* logic/mult_pkg.sv */
// --------------------------------------------------
// Shared sizes, operation codes and payload structs
// for the multiply execution unit. QUEUE_DEPTH must
// be a power of two.
// --------------------------------------------------

package mult_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------

    // Operand and result width
    localparam int unsigned XLEN = 64;

    // Width of the tag chosen by the issuer
    localparam int unsigned TAG_LEN = 4;

    // Issue queue entries, also the issuer credit count
    localparam int unsigned QUEUE_DEPTH = 4;

    // Register levels in the multiply pipeline
    localparam int unsigned PIPE_DEPTH = 3;

    // Result credits held by the consumer after reset
    localparam int unsigned OUT_CREDITS = 4;

    // Queue index width, pointers carry one extra wrap bit
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // Result credit counter must hold 0..OUT_CREDITS
    localparam int unsigned CREDIT_W = $clog2(OUT_CREDITS + 1);

    // --------------------------------------------------
    // Operation codes
    // --------------------------------------------------

    // Codes 5 to 7 are illegal and raise an exception
    typedef enum logic [2:0] {
        MULT_MUL    = 3'd0,
        MULT_MULW   = 3'd1,
        MULT_MULH   = 3'd2,
        MULT_MULHU  = 3'd3,
        MULT_MULHSU = 3'd4
    } mult_op_e;

    // --------------------------------------------------
    // Payloads
    // --------------------------------------------------

    // External request, also stored as a queue entry
    typedef struct packed {
        mult_op_e             op;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
        // Echoed back with the result
        logic [TAG_LEN-1:0]   tag;
    } mult_req_t;

    // Pipeline payload and external result
    typedef struct packed {
        logic [XLEN-1:0]      result;
        logic [TAG_LEN-1:0]   tag;
        // Set for illegal operation codes, result is zero
        logic                 except_raised;
    } mult_res_t;

endpackage

/* logic/spill_cell_flush.sv */
// --------------------------------------------------
// Two-entry valid/ready buffer. ready_o depends only
// on local occupancy. Flush drops both entries.
// --------------------------------------------------

module spill_cell_flush #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  valid_i,
    input  logic  ready_i,
    input  DATA_T data_i,
    output logic  valid_o,
    output logic  ready_o,
    output DATA_T data_o
);

    // Main register drives the output, spill catches a stalled beat
    logic  main_valid_q;
    logic  spill_valid_q;
    DATA_T main_data_q;
    DATA_T spill_data_q;

    logic  in_fire;
    logic  main_free;

    // Accept while the spill slot is empty
    assign ready_o   = ~spill_valid_q;
    assign valid_o   = main_valid_q;
    assign data_o    = main_data_q;

    assign in_fire   = valid_i & ready_o;
    // Main slot can take a new beat this cycle
    assign main_free = ~main_valid_q | ready_i;

    // Occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (flush_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (main_free) begin
            // Spilled beat moves up first, input blocked meanwhile
            main_valid_q  <= spill_valid_q | in_fire;
            spill_valid_q <= 1'b0;
        end else if (in_fire) begin
            spill_valid_q <= 1'b1;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (main_free) begin
            main_data_q <= spill_valid_q ? spill_data_q : data_i;
        end else if (in_fire) begin
            spill_data_q <= data_i;
        end
    end

endmodule

/* logic/mult_issue_queue.sv */
// --------------------------------------------------
// Credit-fed request FIFO. The issuer must not send
// more than QUEUE_DEPTH requests without a credit.
// Issue needs a free result credit.
// --------------------------------------------------

module mult_issue_queue
    import mult_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    // Issuer side
    input  logic      req_valid_i,
    input  mult_req_t req_i,
    output logic      req_credit_o,
    // Consumer credit return
    input  logic      res_credit_i,
    // Towards the issue spill cell
    input  logic      issue_ready_i,
    output logic      issue_valid_o,
    output mult_req_t issue_o
);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------

    mult_req_t queue_q [QUEUE_DEPTH];

    // MSB is the wrap bit used to tell full from empty
    logic [QUEUE_PTR_W:0] wr_ptr_q;
    logic [QUEUE_PTR_W:0] rd_ptr_q;

    // Free result slots downstream
    logic [CREDIT_W-1:0]  res_credits_q;

    logic empty;
    logic full;
    logic push;
    logic issue_fire;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[QUEUE_PTR_W] != rd_ptr_q[QUEUE_PTR_W]) &&
                   (wr_ptr_q[QUEUE_PTR_W-1:0] == rd_ptr_q[QUEUE_PTR_W-1:0]);

    // Full never happens with a well-behaved issuer
    assign push = req_valid_i & ~full & ~flush_i;

    // --------------------------------------------------
    // Issue
    // --------------------------------------------------

    // Head entry goes out only with a reserved result slot
    assign issue_valid_o = ~empty & (res_credits_q != '0) & ~flush_i;
    assign issue_o       = queue_q[rd_ptr_q[QUEUE_PTR_W-1:0]];
    assign issue_fire    = issue_valid_o & issue_ready_i;

    // One issuer credit back per entry that leaves
    assign req_credit_o  = issue_fire;

    // Pointers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (issue_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q[QUEUE_PTR_W-1:0]] <= req_i;
        end
    end

    // --------------------------------------------------
    // Result credit counter
    // --------------------------------------------------

    // Consumer returns and issues may coincide
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_credits_q <= CREDIT_W'(OUT_CREDITS);
        end else if (flush_i) begin
            res_credits_q <= CREDIT_W'(OUT_CREDITS);
        end else begin
            res_credits_q <= res_credits_q + CREDIT_W'(res_credit_i)
                             - CREDIT_W'(issue_fire);
        end
    end

endmodule

/* logic/mult_unit.sv */
// --------------------------------------------------
// Decode, 64x64 multiply and a PIPE_DEPTH register
// pipeline. All stages stall together on ready_i.
// A MUL right after a MULH-family op on the same
// operands reuses the cached low half.
// --------------------------------------------------

module mult_unit
    import mult_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      valid_i,
    input  mult_req_t req_i,
    input  logic      ready_i,
    output logic      ready_o,
    output logic      valid_o,
    output mult_res_t res_o
);

    // --------------------------------------------------
    // Stage 0 decode and multiply
    // --------------------------------------------------

    // Operands widened by one bit so one signed multiplier serves all ops
    logic signed [XLEN:0]     op_a;
    logic signed [XLEN:0]     op_b;
    logic signed [2*XLEN+1:0] prod_wide;
    logic [2*XLEN-1:0]        product;

    // Operand cache
    logic                     cache_valid_q;
    logic [XLEN-1:0]          cache_rs1_q;
    logic [XLEN-1:0]          cache_rs2_q;
    logic [XLEN-1:0]          cache_low_q;
    logic                     cache_hit;
    logic                     cache_en;
    logic                     is_mulh_family;

    mult_res_t                stage0_res;
    logic                     advance;

    // Pipeline registers
    logic                     pipe_valid_q [PIPE_DEPTH];
    mult_res_t                pipe_res_q   [PIPE_DEPTH];

    // Whole pipeline moves only when the last stage is taken
    assign advance = ready_i;
    assign ready_o = ready_i;

    // Sign extension only where the op treats the operand as signed
    always_comb begin
        op_a = {(req_i.op != MULT_MULHU) & req_i.rs1[XLEN-1], req_i.rs1};
        op_b = {((req_i.op == MULT_MUL) | (req_i.op == MULT_MULH)) & req_i.rs2[XLEN-1],
                req_i.rs2};
    end

    assign prod_wide = op_a * op_b;
    assign product   = prod_wide[2*XLEN-1:0];

    assign is_mulh_family = (req_i.op == MULT_MULH) | (req_i.op == MULT_MULHU) |
                            (req_i.op == MULT_MULHSU);

    assign cache_hit = cache_valid_q & (req_i.op == MULT_MUL) &
                       (req_i.rs1 == cache_rs1_q) & (req_i.rs2 == cache_rs2_q);

    // Store operands of every accepted MULH-family request
    assign cache_en  = valid_i & ready_o & ~flush_i & is_mulh_family;

    // Result half selection
    always_comb begin
        stage0_res               = '0;
        stage0_res.tag           = req_i.tag;
        unique case (req_i.op)
            MULT_MUL: begin
                stage0_res.result = cache_hit ? cache_low_q : product[XLEN-1:0];
            end
            MULT_MULW: begin
                // Low 32 bits only depend on the low operand halves
                stage0_res.result = {{(XLEN/2){product[XLEN/2-1]}}, product[XLEN/2-1:0]};
            end
            MULT_MULH, MULT_MULHU, MULT_MULHSU: begin
                stage0_res.result = product[2*XLEN-1:XLEN];
            end
            default: begin
                // Illegal code, zero result
                stage0_res.except_raised = 1'b1;
            end
        endcase
    end

    // Cache valid bit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cache_valid_q <= 1'b0;
        end else if (cache_en) begin
            cache_valid_q <= 1'b1;
        end
    end

    // Cached operands and low half
    always_ff @(posedge clk_i) begin
        if (cache_en) begin
            cache_rs1_q <= req_i.rs1;
            cache_rs2_q <= req_i.rs2;
            cache_low_q <= product[XLEN-1:0];
        end
    end

    // --------------------------------------------------
    // Pipeline
    // --------------------------------------------------

    // Valid bits, bubbles enter when valid_i is low
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                pipe_valid_q[i] <= 1'b0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                pipe_valid_q[i] <= 1'b0;
            end
        end else if (advance) begin
            pipe_valid_q[0] <= valid_i;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                pipe_valid_q[i] <= pipe_valid_q[i-1];
            end
        end
    end

    // Payload shift
    always_ff @(posedge clk_i) begin
        if (advance) begin
            pipe_res_q[0] <= stage0_res;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                pipe_res_q[i] <= pipe_res_q[i-1];
            end
        end
    end

    assign valid_o = pipe_valid_q[PIPE_DEPTH-1];
    assign res_o   = pipe_res_q[PIPE_DEPTH-1];

endmodule

/* logic/mult_eu_top.sv */
// --------------------------------------------------
// Multiply execution unit. Credit flow on both ends,
// consumer must always accept a result. Minimum
// latency is PIPE_DEPTH + 3 cycles.
// --------------------------------------------------

module mult_eu_top
    import mult_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    // Issuer
    input  logic      req_valid_i,
    input  mult_req_t req_i,
    output logic      req_credit_o,
    // Consumer
    input  logic      res_credit_i,
    output logic      res_valid_o,
    output mult_res_t res_o
);

    // --------------------------------------------------
    // Internal handshakes
    // --------------------------------------------------

    // Queue to issue cell
    logic      q_valid;
    logic      q_ready;
    mult_req_t q_req;

    // Issue cell to unit
    logic      iss_valid;
    logic      iss_ready;
    mult_req_t iss_req;

    // Unit to result cell
    logic      mu_valid;
    logic      mu_ready;
    mult_res_t mu_res;

    mult_issue_queue u_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_credit_o  (req_credit_o),
        .res_credit_i  (res_credit_i),
        .issue_ready_i (q_ready),
        .issue_valid_o (q_valid),
        .issue_o       (q_req)
    );

    spill_cell_flush #(.DATA_T(mult_req_t)) u_issue_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (q_valid),
        .ready_i (iss_ready),
        .data_i  (q_req),
        .valid_o (iss_valid),
        .ready_o (q_ready),
        .data_o  (iss_req)
    );

    mult_unit u_unit (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (iss_valid),
        .req_i   (iss_req),
        .ready_i (mu_ready),
        .ready_o (iss_ready),
        .valid_o (mu_valid),
        .res_o   (mu_res)
    );

    // Credits guarantee acceptance, so the output side is always ready
    spill_cell_flush #(.DATA_T(mult_res_t)) u_result_cell (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (mu_valid),
        .ready_i (1'b1),
        .data_i  (mu_res),
        .valid_o (res_valid_o),
        .ready_o (mu_ready),
        .data_o  (res_o)
    );

endmodule

/* tests/mult_eu_assert.sv */
// --------------------------------------------------
// Credit and handshake checks, bound into every
// mult_issue_queue instance.
// --------------------------------------------------

module mult_eu_assert
    import mult_pkg::*;
(
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 flush_i,
    input logic                 issue_valid_i,
    input logic                 issue_ready_i,
    input logic                 res_credit_i,
    input logic                 req_credit_i,
    input logic [CREDIT_W-1:0]  res_credits_i,
    input logic [QUEUE_PTR_W:0] rd_ptr_i
);

    logic                 issue_fire;
    // Head pointer after one entry leaves, wrap bit included
    logic [QUEUE_PTR_W:0] rd_ptr_next;
    // Issued results the consumer has not paid back yet
    int                   outstanding_q;

    assign issue_fire  = issue_valid_i & issue_ready_i;
    assign rd_ptr_next = rd_ptr_i + 1'b1;

    // Shadow of the reservation, kept apart from the queue counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 0;
        end else if (flush_i) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q + int'(issue_fire) - int'(res_credit_i);
        end
    end

    // Underflow wraps above the limit and is caught here too
    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_credits_i <= CREDIT_W'(OUT_CREDITS))
        else $error("Result credit counter outside 0..OUT_CREDITS");

    no_issue_at_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_fire |-> outstanding_q < int'(OUT_CREDITS))
        else $error("Queue issued with all result slots already taken");

    credit_moves_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_credit_i && !flush_i |=> rd_ptr_i == $past(rd_ptr_next))
        else $error("Issuer credit pulsed but the head entry did not leave");

    head_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !req_credit_i && !flush_i |=> rd_ptr_i == $past(rd_ptr_i))
        else $error("Head entry left without an issuer credit pulse");

endmodule

bind mult_issue_queue mult_eu_assert u_queue_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .res_credit_i  (res_credit_i),
    .req_credit_i  (req_credit_o),
    .res_credits_i (res_credits_q),
    .rd_ptr_i      (rd_ptr_q)
);

/* tests/tb_mult_eu.sv */
// --------------------------------------------------
// Vector-driven testbench for mult_eu_top. Runs from
// the project root, reads tests/mult_vectors.txt and
// plays a credit-obeying issuer and consumer.
// --------------------------------------------------

module tb_mult_eu
    import mult_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 2;
    localparam int RAND_SEED    = 83065;
    localparam string VECTOR_FILE = "tests/mult_vectors.txt";

    // DUT ports
    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      req_valid;
    mult_req_t req;
    logic      req_credit;
    logic      res_credit;
    logic      res_valid;
    mult_res_t res;

    // Vector table, one entry per file line
    string     vec_name  [$];
    mult_req_t vec_req   [$];
    mult_res_t vec_exp   [$];
    logic      vec_flush [$];

    // Vector indices still owed a result, in request order
    int        expected   [$];
    // Cycle at which each owed result credit goes back
    int        credit_due [$];

    int        issuer_credits;
    int        cycle;
    int        cycle_limit;
    int        errors;
    // Set once the run has printed its verdict
    bit        verdict_printed;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    mult_eu_top uut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_o (req_credit),
        .res_credit_i (res_credit),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic report_failure(input string why);
        errors++;
        verdict_printed = 1'b1;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped after a failed check");
    endtask

    // Comment lines start with # and are skipped
    task automatic load_vectors();
        int                 fd;
        int                 fields;
        string              line;
        string              name;
        logic [2:0]         op;
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    rs2;
        logic [XLEN-1:0]    result;
        logic [TAG_LEN-1:0] tag;
        logic               exc;
        logic               fl;
        mult_req_t          r;
        mult_res_t          e;
        fd = $fopen(VECTOR_FILE, "r");
        assert (fd != 0) else report_failure("Cannot open the vector file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h",
                             name, op, rs1, rs2, tag, result, exc, fl);
            assert (fields == 8) else report_failure({"Malformed vector line ", line});
            r.op  = mult_op_e'(op);
            r.rs1 = rs1;
            r.rs2 = rs2;
            r.tag = tag;
            e.result        = result;
            e.tag           = tag;
            e.except_raised = exc;
            vec_name.push_back(name);
            vec_req.push_back(r);
            vec_exp.push_back(e);
            vec_flush.push_back(fl);
        end
        $fclose(fd);
    endtask

    // Result against the oldest outstanding request
    task automatic check_result();
        int idx;
        assert (expected.size() != 0)
            else report_failure("A result arrived while no request was outstanding");
        idx = expected.pop_front();
        assert (res == vec_exp[idx]) else begin
            report_failure($sformatf(
                "MISMATCH %s expected result=%h tag=%h except=%b actual result=%h tag=%h except=%b",
                vec_name[idx], vec_exp[idx].result, vec_exp[idx].tag,
                vec_exp[idx].except_raised, res.result, res.tag, res.except_raised));
        end
        // Consumer hands the slot back 0 to 3 cycles later
        credit_due.push_back(cycle + int'($urandom_range(3, 0)));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        int vi;
        bit flushed_for_vi;
        void'($urandom(RAND_SEED));
        rst_n      = 1'b0;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        res_credit = 1'b0;
        errors         = 0;
        cycle          = 0;
        vi             = 0;
        flushed_for_vi = 1'b0;
        issuer_credits = QUEUE_DEPTH;
        load_vectors();
        cycle_limit = 40 * vec_name.size() + 100;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b1;

        while (vi < vec_name.size() || expected.size() != 0) begin
            @(posedge clk);
            cycle++;
            assert (cycle <= cycle_limit)
                else report_failure("Timeout, results stopped arriving before the vectors ran out");
            #(DRIVE_DELAY);
            req_valid  = 1'b0;
            flush      = 1'b0;
            res_credit = 1'b0;
            // Flush marker fires once, the marked vector follows it
            if (vi < vec_name.size()) begin
                if (vec_flush[vi] && !flushed_for_vi) begin
                    flush          = 1'b1;
                    flushed_for_vi = 1'b1;
                end else if (issuer_credits > 0) begin
                    req            = vec_req[vi];
                    req_valid      = 1'b1;
                    issuer_credits--;
                    expected.push_back(vi);
                    vi++;
                    flushed_for_vi = 1'b0;
                end
            end
            if (!flush && credit_due.size() != 0 && credit_due[0] <= cycle) begin
                credit_due.delete(0);
                res_credit = 1'b1;
            end

            // Outputs are settled by the falling edge
            @(negedge clk);
            if (flush) begin
                // In-flight work is dropped and both credit sides start over
                expected.delete();
                credit_due.delete();
                issuer_credits = QUEUE_DEPTH;
            end else begin
                if (res_valid) begin
                    check_result();
                end
                if (req_credit) begin
                    issuer_credits++;
                end
                assert (issuer_credits <= QUEUE_DEPTH)
                    else report_failure("Issuer got back more credits than queue entries");
            end
        end

        assert (issuer_credits == QUEUE_DEPTH)
            else report_failure("Issuer credits were not all returned at the end");
        verdict_printed = 1'b1;
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run ended before the main sequence reached a verdict
    final begin
        if (!verdict_printed) begin
            $display("Finished with errors");
        end
    end

endmodule

/* tests/mult_vectors.txt */
# Columns name op rs1 rs2 tag exp_result exp_except flush
# Numbers are hex and flush 1 asserts flush_i for a cycle before that vector is sent
# Corner operands for every legal operation
mul_small           0 0000000000000003 0000000000000005 0 000000000000000f 0 0
mul_neg1_x7         0 ffffffffffffffff 0000000000000007 1 fffffffffffffff9 0 0
mul_min_x_neg1      0 8000000000000000 ffffffffffffffff 2 8000000000000000 0 0
mul_min_x_zero      0 8000000000000000 0000000000000000 3 0000000000000000 0 0
mulh_small          2 0000000000000003 0000000000000005 4 0000000000000000 0 0
mulh_neg1_x7        2 ffffffffffffffff 0000000000000007 5 ffffffffffffffff 0 0
mulh_min_x_min      2 8000000000000000 8000000000000000 6 4000000000000000 0 0
mulh_min_x_neg1     2 8000000000000000 ffffffffffffffff 7 0000000000000000 0 0
mulhu_max_x_max     3 ffffffffffffffff ffffffffffffffff 8 fffffffffffffffe 0 0
mulhu_min_x_2       3 8000000000000000 0000000000000002 9 0000000000000001 0 0
mulhsu_neg1_x_max   4 ffffffffffffffff ffffffffffffffff a ffffffffffffffff 0 0
mulhsu_min_x_2      4 8000000000000000 0000000000000002 b ffffffffffffffff 0 0
mulhsu_16_x_max     4 0000000000000010 ffffffffffffffff c 000000000000000f 0 0
mulw_low_halves     1 0000000100000003 ffffffff00000005 d 000000000000000f 0 0
mulw_sign_ext       1 0000000040000000 0000000000000002 e ffffffff80000000 0 0
mulw_neg1_x3        1 ffffffffffffffff 0000000000000003 f fffffffffffffffd 0 0
# MUL right after a MULH-family op, same operands hit and swapped ones miss
hit_mulhu           3 ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 0 0
hit_mul_after_hu    0 ffffffffffffffff ffffffffffffffff 1 0000000000000001 0 0
hit_mulhsu          4 0000000000000010 ffffffffffffffff 2 000000000000000f 0 0
hit_mul_after_hsu   0 0000000000000010 ffffffffffffffff 3 fffffffffffffff0 0 0
hit_mulh            2 0000000123456789 0000000000000100 4 0000000000000000 0 0
hit_mul_after_h     0 0000000123456789 0000000000000100 5 0000012345678900 0 0
miss_mulh           2 0000000000000007 0000000000000009 6 0000000000000000 0 0
miss_mul_swapped    0 0000000000000009 0000000000000007 7 000000000000003f 0 0
# Illegal codes give zero with the exception flag and keep the tag
illegal_op5         5 0000000000000003 0000000000000005 8 0000000000000000 1 0
illegal_op6         6 ffffffffffffffff 8000000000000000 9 0000000000000000 1 0
illegal_op7         7 0000000000000000 0000000000000000 a 0000000000000000 1 0
# Work in flight before the marker is dropped
pre_flush_mul       0 0000000000000002 0000000000000003 b 0000000000000006 0 0
pre_flush_mul2      0 0000000000000004 0000000000000005 c 0000000000000014 0 0
pre_flush_mulh      2 8000000000000000 8000000000000000 d 4000000000000000 0 0
post_flush_mul      0 0000000000000006 0000000000000007 e 000000000000002a 0 1
post_flush_mulhu    3 8000000000000000 0000000000000004 f 0000000000000002 0 0
post_flush_mulw     1 000000007fffffff 000000007fffffff 0 0000000000000001 0 0
post_flush_mul_wide 0 00000000ffffffff 00000000ffffffff 1 fffffffe00000001 0 0

/* filelist.f */
logic/mult_pkg.sv
logic/spill_cell_flush.sv
logic/mult_issue_queue.sv
logic/mult_unit.sv
logic/mult_eu_top.sv
tests/mult_eu_assert.sv
tests/tb_mult_eu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the multiply unit testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mult_eu -Mdir obj_dir -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mult_eu 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
